// File: common/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	typedef enum logic [2:0] {
		idle,
		write_cache,
		read,
		read_valid,
		write_mem,
		resp
	} ctrl_state_t;

	// Status from the datapath, combinational from the address and the arrays
	typedef struct packed {
		logic                      hit;
		cache_types_pkg::way_idx_t hit_way;
		cache_types_pkg::way_idx_t victim;
		logic                      victim_dirty;
		logic [1:0]                spare;
	} dp_status_t;

	// Strobes and selects from the controller to the datapath
	typedef struct packed {
		cache_types_pkg::way_mask_t ld_line;
		logic                       fill_sel;   // 1 takes the line from pmem_rdata
		cache_types_pkg::way_mask_t ld_meta;
		cache_types_pkg::way_mask_t set_dirty;
		cache_types_pkg::way_mask_t clr_dirty;
		logic                       ld_lru;
		logic                       wb_sel;     // 1 points address and data at the victim
	} dp_ctrl_t;

endpackage : cache_ctrl_pkg

// File: common/cache_types_pkg.sv
package cache_types_pkg;

	// Cache geometry
	localparam int ADDR_W   = 32;
	localparam int LINE_W   = 256;
	localparam int OFFSET_W = 5;
	localparam int INDEX_W  = 3;
	localparam int NUM_SETS = 1 << INDEX_W;
	localparam int NUM_WAYS = 4;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	// Byte address as seen on both the upper and the memory side
	typedef logic [ADDR_W-1:0] addr_t;

	// One whole cache line
	typedef logic [LINE_W-1:0] line_t;

	typedef logic [TAG_W-1:0] tag_t;

	typedef logic [INDEX_W-1:0] index_t;

	typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;

	// One bit per way, used for one-hot load strobes
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	// Tree state of one set
	// Bit 2 picks ways 0/1 or 2/3, bit 1 picks within 0/1, bit 0 within 2/3
	typedef logic [2:0] plru_t;

endpackage : cache_types_pkg

// File: l2_cache/l2_cache.sv
`timescale 1ns/1ps

module l2_cache (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  cache_types_pkg::addr_t mem_address,
	input  cache_types_pkg::line_t mem_wdata,
	output cache_types_pkg::line_t mem_rdata,
	output logic                   mem_resp,
	output logic                   pmem_read,
	output logic                   pmem_write,
	output cache_types_pkg::addr_t pmem_address,
	output cache_types_pkg::line_t pmem_wdata,
	input  cache_types_pkg::line_t pmem_rdata,
	input  logic                   pmem_resp
);

	import cache_ctrl_pkg::*;

	dp_ctrl_t   ctrl;
	dp_status_t status;

	l2_cache_control i_control (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.pmem_resp  (pmem_resp),
		.status     (status),
		.ctrl       (ctrl),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.mem_resp   (mem_resp)
	);

	l2_cache_datapath i_datapath (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_address  (mem_address),
		.mem_wdata    (mem_wdata),
		.pmem_rdata   (pmem_rdata),
		.ctrl         (ctrl),
		.status       (status),
		.mem_rdata    (mem_rdata),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata)
	);

endmodule : l2_cache

// File: l2_cache/l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      mem_read,
	input  logic                      mem_write,
	input  logic                      pmem_resp,
	input  cache_ctrl_pkg::dp_status_t status,
	output cache_ctrl_pkg::dp_ctrl_t   ctrl,
	output logic                      pmem_read,
	output logic                      pmem_write,
	output logic                      mem_resp
);

	import cache_types_pkg::*;
	import cache_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	way_mask_t hit_mask;
	way_mask_t victim_mask;

	assign hit_mask    = way_mask_t'(1'b1) << status.hit_way;
	assign victim_mask = way_mask_t'(1'b1) << status.victim;

	always_comb begin
		ctrl       = '0;
		pmem_read  = 1'b0;
		pmem_write = 1'b0;
		mem_resp   = 1'b0;

		case (state)
			write_cache: begin
				// Write hit stores the upper line in place and marks it dirty
				if (status.hit && mem_write) begin
					ctrl.ld_line   = hit_mask;
					ctrl.set_dirty = hit_mask;
					ctrl.ld_lru    = 1'b1;
				end
			end

			read: begin
				// A dirty victim is written back first, in write_mem
				if (!status.victim_dirty) begin
					pmem_read = 1'b1;
					if (pmem_resp) begin
						ctrl.ld_line  = victim_mask;
						ctrl.fill_sel = 1'b1;
						ctrl.ld_meta  = victim_mask;
					end
				end
			end

			write_mem: begin
				ctrl.wb_sel = 1'b1;
				pmem_write  = 1'b1;
				if (pmem_resp)
					ctrl.clr_dirty = victim_mask;
			end

			resp: begin
				mem_resp    = 1'b1;
				ctrl.ld_lru = 1'b1;
			end

			default: ;
		endcase
	end

	always_comb begin
		next_state = state;

		case (state)
			idle: begin
				if (mem_read || mem_write)
					next_state = write_cache;
			end

			write_cache: begin
				if (status.hit)
					next_state = resp;
				else
					next_state = read;
			end

			read: begin
				if (status.victim_dirty)
					next_state = write_mem;
				else if (pmem_resp) begin
					// A write miss goes back to idle and completes as a hit
					if (mem_read)
						next_state = read_valid;
					else
						next_state = idle;
				end
			end

			read_valid: begin
				next_state = resp;
			end

			write_mem: begin
				if (pmem_resp)
					next_state = read;
			end

			resp: begin
				next_state = idle;
			end

			default: begin
				next_state = idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= next_state;
	end

	a_pmem_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write)
	);

	// The response is a single pulse out of resp
	a_resp_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_resp |-> ((state == resp) ##1 !mem_resp)
	);

endmodule : l2_cache_control

// File: l2_cache/l2_cache_datapath.sv
`timescale 1ns/1ps

module l2_cache_datapath (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_types_pkg::addr_t     mem_address,
	input  cache_types_pkg::line_t     mem_wdata,
	input  cache_types_pkg::line_t     pmem_rdata,
	input  cache_ctrl_pkg::dp_ctrl_t   ctrl,
	output cache_ctrl_pkg::dp_status_t status,
	output cache_types_pkg::line_t     mem_rdata,
	output cache_types_pkg::addr_t     pmem_address,
	output cache_types_pkg::line_t     pmem_wdata
);

	import cache_types_pkg::*;

	way_mask_t valid_q [NUM_SETS];
	way_mask_t dirty_q [NUM_SETS];
	tag_t      tag_q   [NUM_WAYS][NUM_SETS];
	line_t     data_q  [NUM_WAYS][NUM_SETS];

	index_t    idx;
	tag_t      req_tag;
	way_mask_t way_hit;
	way_idx_t  hit_way;
	way_idx_t  victim;
	line_t     line_in;

	assign idx     = mem_address[OFFSET_W +: INDEX_W];
	assign req_tag = mem_address[ADDR_W-1 -: TAG_W];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++)
			way_hit[w] = valid_q[idx][w] && (tag_q[w][idx] == req_tag);
	end

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_hit[w])
				hit_way = way_idx_t'(w);
		end
	end

	plru_tree i_plru_tree (
		.clk      (clk),
		.rst_n    (rst_n),
		.index    (idx),
		.ld_lru   (ctrl.ld_lru),
		.used_way (hit_way),
		.victim   (victim)
	);

	always_comb begin
		status              = '0;
		status.hit          = |way_hit;
		status.hit_way      = hit_way;
		status.victim       = victim;
		status.victim_dirty = dirty_q[idx][victim];
		status.spare        = 2'b00;
	end

	assign line_in = ctrl.fill_sel ? pmem_rdata : mem_wdata;

	// Tag and state bits of all ways
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
				for (int w = 0; w < NUM_WAYS; w++)
					tag_q[w][s] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (ctrl.ld_meta[w]) begin
					tag_q[w][idx]   <= req_tag;
					valid_q[idx][w] <= 1'b1;
				end
				if (ctrl.set_dirty[w])
					dirty_q[idx][w] <= 1'b1;
				else if (ctrl.clr_dirty[w])
					dirty_q[idx][w] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ctrl.ld_line[w])
				data_q[w][idx] <= line_in;
		end
	end

	assign mem_rdata  = data_q[hit_way][idx];
	assign pmem_wdata = data_q[victim][idx];

	// A write-back goes to the victim's own line address
	always_comb begin
		if (ctrl.wb_sel)
			pmem_address = {tag_q[victim][idx], idx, {OFFSET_W{1'b0}}};
		else
			pmem_address = {mem_address[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	end

	a_ld_line_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(ctrl.ld_line)
	);

endmodule : l2_cache_datapath

// File: logic/plru_tree.sv
`timescale 1ns/1ps

module plru_tree (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_types_pkg::index_t   index,
	input  logic                     ld_lru,
	input  cache_types_pkg::way_idx_t used_way,
	output cache_types_pkg::way_idx_t victim
);

	import cache_types_pkg::*;

	plru_t tree_q [NUM_SETS];
	plru_t cur;
	plru_t next_tree;

	assign cur = tree_q[index];

	// Follow the root, then the bit of the chosen pair
	assign victim = cur[2] ? {1'b1, cur[0]} : {1'b0, cur[1]};

	// Point the tree away from the way just used
	always_comb begin
		case (used_way)
			2'd0:    next_tree = {1'b1, 1'b1, cur[0]};
			2'd1:    next_tree = {1'b1, 1'b0, cur[0]};
			2'd2:    next_tree = {1'b0, cur[1], 1'b1};
			default: next_tree = {1'b0, cur[1], 1'b0};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < NUM_SETS; s++)
				tree_q[s] <= '0;
		end else if (ld_lru) begin
			tree_q[index] <= next_tree;
		end
	end

endmodule : plru_tree

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module l2_cache_tb \
	-f tb.f \
	-o l2_cache_sim

./obj_dir/l2_cache_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: tb.f
common/cache_types_pkg.sv
common/cache_ctrl_pkg.sv
logic/plru_tree.sv
l2_cache/l2_cache_control.sv
l2_cache/l2_cache_datapath.sv
l2_cache/l2_cache.sv
verif/pmem_model.sv
verif/l2_cache_tb.sv

// File: verif/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

	import cache_types_pkg::*;

	localparam int PMEM_LATENCY = 5;
	localparam int DRIVE_DLY    = 1;
	localparam int NUM_OPS      = 11;
	localparam int MAX_CYCLES   = NUM_OPS * (2 * PMEM_LATENCY + 10);

	typedef struct packed {
		logic  is_write;
		addr_t addr;
		int    fills;
		int    wbs;
	} op_t;

	logic  clk;
	logic  rst_n;
	logic  mem_read;
	logic  mem_write;
	addr_t mem_address;
	line_t mem_wdata;
	line_t mem_rdata;
	logic  mem_resp;
	logic  pmem_read;
	logic  pmem_write;
	addr_t pmem_address;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic  pmem_resp;

	string       op_name      [NUM_OPS];
	op_t         op_tab       [NUM_OPS];
	line_t       exp_mem      [addr_t];
	plru_t       lru_shadow   [NUM_SETS];
	tag_t        tag_shadow   [NUM_WAYS][NUM_SETS];
	way_mask_t   valid_shadow [NUM_SETS];
	logic [31:0] lfsr_state;
	int          cycle_cnt;

	l2_cache i_l2_cache (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_address  (mem_address),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata),
		.mem_resp     (mem_resp),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

	pmem_model #(.LATENCY(PMEM_LATENCY)) i_pmem_model (
		.clk          (clk),
		.rst_n        (rst_n),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
			fail_run("Timeout: the operation table did not finish within the cycle limit");
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		if (act !== exp)
			fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input integer exp, input integer act);
		if (act !== exp)
			fail_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int b = 0; b < LINE_W; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			l[b] = lfsr_state[0];
		end
		return l;
	endfunction

	function automatic line_t expected_line(input addr_t line_addr);
		if (exp_mem.exists(line_addr))
			return exp_mem[line_addr];
		return {8{line_addr}};
	endfunction

	// The root picks a pair, the pair's own bit picks the way
	function automatic way_idx_t plru_victim(input plru_t t);
		if (!t[2])
			return t[1] ? 2'd1 : 2'd0;
		return t[0] ? 2'd3 : 2'd2;
	endfunction

	// Bits are pointed away from the way that was just used
	function automatic plru_t plru_touch(input plru_t t, input way_idx_t w);
		plru_t n;
		n = t;
		n[2] = (w < 2'd2);
		if (w < 2'd2)
			n[1] = (w == 2'd0);
		else
			n[0] = (w == 2'd2);
		return n;
	endfunction

	task automatic set_op(input int i, input string name, input logic wr, input addr_t addr,
			input int fills, input int wbs);
		op_name[i] = name;
		op_tab[i]  = '{is_write: wr, addr: addr, fills: fills, wbs: wbs};
	endtask

	task automatic apply_op(input int i);
		string    name;
		addr_t    line_addr;
		addr_t    wb_addr;
		index_t   set_idx;
		tag_t     tag;
		way_idx_t way;
		line_t    wdata;
		logic     hit;
		logic     done;
		int       cycles;
		int       fills;
		int       wbs;

		name      = op_name[i];
		line_addr = {op_tab[i].addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		set_idx   = op_tab[i].addr[OFFSET_W +: INDEX_W];
		tag       = op_tab[i].addr[ADDR_W-1 -: TAG_W];

		// Shadow lookup picks the way this access ends in
		hit = 1'b0;
		way = plru_victim(lru_shadow[set_idx]);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (valid_shadow[set_idx][w] && tag_shadow[w][set_idx] == tag) begin
				hit = 1'b1;
				way = way_idx_t'(w);
			end
		end
		wb_addr = {tag_shadow[way][set_idx], set_idx, {OFFSET_W{1'b0}}};
		if (!hit) begin
			tag_shadow[way][set_idx]   = tag;
			valid_shadow[set_idx][way] = 1'b1;
		end
		lru_shadow[set_idx] = plru_touch(lru_shadow[set_idx], way);

		wdata = '0;
		if (op_tab[i].is_write)
			wdata = random_line();

		@(posedge clk);
		#DRIVE_DLY;
		mem_address = op_tab[i].addr;
		mem_wdata   = wdata;
		mem_read    = !op_tab[i].is_write;
		mem_write   = op_tab[i].is_write;

		cycles = 0;
		fills  = 0;
		wbs    = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (pmem_resp && pmem_write) begin
				wbs++;
				check_count({name, " fills before write-back"}, 0, fills);
				check_addr({name, " write-back address"}, wb_addr, pmem_address);
				check_line({name, " write-back data"}, expected_line(wb_addr), pmem_wdata);
			end
			if (pmem_resp && pmem_read) begin
				fills++;
				check_addr({name, " fill address"}, line_addr, pmem_address);
				check_line({name, " fill data"}, expected_line(line_addr), pmem_rdata);
			end
			if (mem_resp)
				done = 1'b1;
		end

		if (op_tab[i].is_write)
			exp_mem[line_addr] = wdata;
		else
			check_line({name, " read data"}, expected_line(line_addr), mem_rdata);
		check_count({name, " fills"}, op_tab[i].fills, fills);
		check_count({name, " write-backs"}, op_tab[i].wbs, wbs);
		if (op_tab[i].fills == 0)
			check_count({name, " response cycle"}, 3, cycles);

		@(posedge clk);
		#DRIVE_DLY;
		mem_read  = 1'b0;
		mem_write = 1'b0;
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_address = '0;
		mem_wdata   = '0;
		lfsr_state  = 32'h5706;
		cycle_cnt   = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			lru_shadow[s]   = '0;
			valid_shadow[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				tag_shadow[w][s] = '0;
		end

		//     name              write  address        fills  write-backs
		set_op(0,  "rd_miss",        1'b0, 32'h0000_0104, 1, 0);
		set_op(1,  "rd_hit",         1'b0, 32'h0000_011C, 0, 0);
		set_op(2,  "wr_miss",        1'b1, 32'h0000_0128, 1, 0);
		set_op(3,  "rd_written",     1'b0, 32'h0000_0134, 0, 0);
		set_op(4,  "fill_way_a",     1'b1, 32'h0000_1040, 1, 0);
		set_op(5,  "fill_way_b",     1'b1, 32'h0000_1140, 1, 0);
		set_op(6,  "fill_way_c",     1'b1, 32'h0000_1240, 1, 0);
		set_op(7,  "fill_way_d",     1'b1, 32'h0000_1340, 1, 0);
		set_op(8,  "evict_dirty",    1'b1, 32'h0000_1440, 1, 1);
		set_op(9,  "reread_evicted", 1'b0, 32'h0000_105C, 1, 1);
		set_op(10, "rd_fifth_tag",   1'b0, 32'h0000_1448, 0, 0);

		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		@(negedge clk);
		check_count("reset mem_resp", 0, {31'd0, mem_resp});
		check_count("reset pmem_read", 0, {31'd0, pmem_read});
		check_count("reset pmem_write", 0, {31'd0, pmem_write});

		for (int i = 0; i < NUM_OPS; i++)
			apply_op(i);

		$display("Test OK");
		$finish;
	end

endmodule : l2_cache_tb

// File: verif/pmem_model.sv
`timescale 1ns/1ps

module pmem_model #(
	parameter int LATENCY = 5
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pmem_read,
	input  logic                   pmem_write,
	input  cache_types_pkg::addr_t pmem_address,
	input  cache_types_pkg::line_t pmem_wdata,
	output cache_types_pkg::line_t pmem_rdata,
	output logic                   pmem_resp
);

	import cache_types_pkg::*;

	// Lines written back by the cache, keyed by line address
	line_t lines [addr_t];
	int    wait_cnt;

	// A line that was never written holds its own address in every word
	function automatic line_t stored_line(input addr_t addr);
		if (lines.exists(addr))
			return lines[addr];
		return {8{addr}};
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt   <= 0;
			pmem_resp  <= 1'b0;
			pmem_rdata <= '0;
		end else begin
			pmem_resp <= 1'b0;
			// The cycle after a response never starts a new count
			if ((pmem_read || pmem_write) && !pmem_resp) begin
				if (wait_cnt == LATENCY - 1) begin
					wait_cnt  <= 0;
					pmem_resp <= 1'b1;
					if (pmem_write)
						lines[pmem_address] = pmem_wdata;
					else
						pmem_rdata <= stored_line(pmem_address);
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule : pmem_model
